/* bench/tb_reduce_cluster.sv */
`default_nettype none

`include "red_params.svh"

module tb_reduce_cluster;
    timeunit 1ns;
    timeprecision 1ps;

    import red_pkg::*;

    localparam int NUM_INSTR      = 150;
    localparam int TOTAL_COMMITS  = 2 * NUM_INSTR * `RED_NUM_PACKETS;
    localparam int TIMEOUT_CYCLES = 2 * NUM_INSTR * 20 + 100;
    localparam int WARP_LANES     = `RED_NUM_PACKETS * `RED_NUM_LANES;

    // one expected commit as the reference model sees it
    typedef struct packed {
        logic [15:0] idx;
        red_mask_t   tmask;
        red_tag_t    tag;
        red_word_t   result;
    } exp_t;

    logic                           clk;
    logic                           reset;
    logic                           ex_valid [2];
    logic                           ex_ready [2];
    red_op_e                        ex_op    [2];
    red_mask_t                      ex_tmask [2];
    red_word_t [`RED_NUM_LANES-1:0] ex_data  [2];
    red_tag_t                       ex_tag   [2];
    logic                           commit_valid;
    logic                           commit_ready;
    red_mask_t                      commit_tmask;
    red_word_t [`RED_NUM_LANES-1:0] commit_data;
    red_tag_t                       commit_tag;
    logic                           commit_unit;

    integer                         seed;
    int                             cycles;
    int                             n_commits;

    // stimulus for each unit, instruction and packet, built before reset is released
    red_op_e                        ins_op   [2][NUM_INSTR];
    logic [1:0]                     ins_wid  [2][NUM_INSTR];
    logic [4:0]                     ins_rd   [2][NUM_INSTR];
    red_mask_t                      ins_mask [2][NUM_INSTR][`RED_NUM_PACKETS];
    red_word_t [`RED_NUM_LANES-1:0] ins_data [2][NUM_INSTR][`RED_NUM_PACKETS];
    int                             ins_gap  [2][NUM_INSTR][`RED_NUM_PACKETS];

    exp_t                           exp_q0 [$];
    exp_t                           exp_q1 [$];

    // monitor state, busy means the unit owes commits for a finished warp
    logic                           busy [2];
    logic                           last_winner;
    logic                           prev_stall;
    logic                           prev_unit;
    red_mask_t                      prev_tmask;
    red_tag_t                       prev_tag;
    red_word_t [`RED_NUM_LANES-1:0] prev_data;

    reduce_cluster dut (
        .clk          (clk),
        .reset        (reset),
        .exec0_valid  (ex_valid[0]),
        .exec0_op     (ex_op[0]),
        .exec0_tmask  (ex_tmask[0]),
        .exec0_data   (ex_data[0]),
        .exec0_tag    (ex_tag[0]),
        .exec0_ready  (ex_ready[0]),
        .exec1_valid  (ex_valid[1]),
        .exec1_op     (ex_op[1]),
        .exec1_tmask  (ex_tmask[1]),
        .exec1_data   (ex_data[1]),
        .exec1_tag    (ex_tag[1]),
        .exec1_ready  (ex_ready[1]),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_tmask (commit_tmask),
        .commit_data  (commit_data),
        .commit_tag   (commit_tag),
        .commit_unit  (commit_unit)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input red_word_t exp, input red_word_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input red_mask_t exp, input red_mask_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name, input red_tag_t exp, input red_tag_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // one step of the reduction on two active values
    function automatic red_word_t apply_op(input red_op_e op, input red_word_t a,
                                           input red_word_t b);
        case (op)
            RED_ADD:  return a + b;
            RED_MIN:  return (int'(a) <= int'(b)) ? a : b;
            RED_MINU: return ({1'b0, a} <= {1'b0, b}) ? a : b;
            RED_MAX:  return (int'(a) >= int'(b)) ? a : b;
            RED_MAXU: return ({1'b0, a} >= {1'b0, b}) ? a : b;
            RED_AND:  return a & b;
            RED_OR:   return a | b;
            default:  return a ^ b;
        endcase
    endfunction

    // the result over all active threads of the warp, zero if none is active
    function automatic red_word_t warp_result(input red_op_e op,
                                              input red_word_t [WARP_LANES-1:0] vals,
                                              input logic [WARP_LANES-1:0] act);
        red_word_t res;
        logic      found;
        res   = '0;
        found = 1'b0;
        for (int t = 0; t < WARP_LANES; t++) begin
            if (act[t]) begin
                res   = found ? apply_op(op, res, vals[t]) : vals[t];
                found = 1'b1;
            end
        end
        return res;
    endfunction

    // range edges come up often so signed and unsigned compares both get exercised
    function automatic red_word_t pick_word();
        case ({$random(seed)} % 8)
            0:       return 32'h0000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'hffff_ffff;
            4:       return 32'h0000_0001;
            default: return $random(seed);
        endcase
    endfunction

    function automatic red_mask_t pick_mask();
        case ({$random(seed)} % 6)
            0:       return '0;
            1:       return '1;
            default: return red_mask_t'($random(seed));
        endcase
    endfunction

    task automatic build_stimulus();
        red_word_t [WARP_LANES-1:0] vals;
        logic [WARP_LANES-1:0]      act;
        red_word_t                  res;
        exp_t                       e;
        for (int u = 0; u < 2; u++) begin
            for (int i = 0; i < NUM_INSTR; i++) begin
                ins_op[u][i]  = red_op_e'(3'($random(seed)));
                ins_wid[u][i] = 2'($random(seed));
                ins_rd[u][i]  = 5'($random(seed));
                for (int p = 0; p < `RED_NUM_PACKETS; p++) begin
                    // every 25th warp has no active thread at all
                    ins_mask[u][i][p] = (i % 25 == 24) ? '0 : pick_mask();
                    ins_gap[u][i][p]  = ({$random(seed)} % 2 == 0) ? 0 : int'({$random(seed)} % 4);
                    for (int l = 0; l < `RED_NUM_LANES; l++) begin
                        ins_data[u][i][p][l]            = pick_word();
                        vals[p * `RED_NUM_LANES + l] = ins_data[u][i][p][l];
                        act[p * `RED_NUM_LANES + l]  = ins_mask[u][i][p][l];
                    end
                end
                res = warp_result(ins_op[u][i], vals, act);
                for (int p = 0; p < `RED_NUM_PACKETS; p++) begin
                    e.idx     = 16'(i);
                    e.tmask   = ins_mask[u][i][p];
                    e.tag.wid = ins_wid[u][i];
                    e.tag.rd  = ins_rd[u][i];
                    e.tag.pid = red_pid_t'(p);
                    e.tag.sop = (p == 0);
                    e.tag.eop = (p == `RED_NUM_PACKETS - 1);
                    e.result  = res;
                    if (u == 0) begin
                        exp_q0.push_back(e);
                    end else begin
                        exp_q1.push_back(e);
                    end
                end
            end
        end
    endtask

    // issue the packets of one unit, holding each until the unit takes it
    task automatic drive_unit(input int u);
        logic fired;
        for (int i = 0; i < NUM_INSTR; i++) begin
            for (int p = 0; p < `RED_NUM_PACKETS; p++) begin
                ex_valid[u] = 1'b0;
                repeat (ins_gap[u][i][p]) begin
                    @(posedge clk);
                    #1;
                end
                ex_valid[u]     = 1'b1;
                ex_op[u]        = ins_op[u][i];
                ex_tmask[u]     = ins_mask[u][i][p];
                ex_data[u]      = ins_data[u][i][p];
                ex_tag[u].wid   = ins_wid[u][i];
                ex_tag[u].rd    = ins_rd[u][i];
                ex_tag[u].pid   = red_pid_t'(p);
                ex_tag[u].sop   = (p == 0);
                ex_tag[u].eop   = (p == `RED_NUM_PACKETS - 1);
                fired = 1'b0;
                while (!fired) begin
                    @(negedge clk);
                    fired = ex_ready[u];
                    @(posedge clk);
                    #1;
                end
            end
        end
        ex_valid[u] = 1'b0;
    endtask

    task automatic check_commit();
        exp_t  e;
        int    pending;
        string name;
        pending = commit_unit ? exp_q1.size() : exp_q0.size();
        if (pending == 0) begin
            $display("unit %0d sent a commit with no instruction outstanding", commit_unit);
            abort_run();
        end else begin
            e    = commit_unit ? exp_q1.pop_front() : exp_q0.pop_front();
            name = $sformatf("unit%0d instr %0d pid %0d", commit_unit, e.idx, e.tag.pid);
            check_mask({name, " tmask"}, e.tmask, commit_tmask);
            check_tag({name, " tag"}, e.tag, commit_tag);
            for (int l = 0; l < `RED_NUM_LANES; l++) begin
                check_word($sformatf("%s result lane %0d", name, l), e.result, commit_data[l]);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_bit("commit_valid while results are owed", busy[0] || busy[1], commit_valid);
            check_bit("exec0_ready", !busy[0], ex_ready[0]);
            check_bit("exec1_ready", !busy[1], ex_ready[1]);
            if (prev_stall) begin
                // a stalled commit must stay exactly as it was
                check_bit("stalled commit_unit", prev_unit, commit_unit);
                check_mask("stalled commit_tmask", prev_tmask, commit_tmask);
                check_tag("stalled commit_tag", prev_tag, commit_tag);
                for (int l = 0; l < `RED_NUM_LANES; l++) begin
                    check_word("stalled commit_data", prev_data[l], commit_data[l]);
                end
            end else if (busy[0] && busy[1]) begin
                check_bit("round-robin grant", !last_winner, commit_unit);
            end else if (busy[0] || busy[1]) begin
                check_bit("single requester grant", busy[1], commit_unit);
            end
            if (commit_valid && commit_ready) begin
                check_commit();
                last_winner = commit_unit;
                n_commits++;
                if (commit_tag.eop) begin
                    busy[commit_unit] = 1'b0;
                end
            end
            for (int u = 0; u < 2; u++) begin
                if (ex_valid[u] && ex_ready[u] && ex_tag[u].eop) begin
                    busy[u] = 1'b1;
                end
            end
            prev_stall = commit_valid && !commit_ready;
            prev_unit  = commit_unit;
            prev_tmask = commit_tmask;
            prev_tag   = commit_tag;
            prev_data  = commit_data;
        end
    end

    // back-pressure on the shared bus, high 70 percent of the time
    always @(posedge clk) begin
        #1;
        commit_ready = ({$random(seed)} % 100) < 70;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run hung: %0d of %0d commits seen after %0d cycles",
                     n_commits, TOTAL_COMMITS, cycles);
            abort_run();
        end
    end

    initial begin
        seed         = 32'h63efdd09;
        clk          = 1'b0;
        reset        = 1'b1;
        commit_ready = 1'b0;
        cycles       = 0;
        n_commits    = 0;
        last_winner  = 1'b1;
        prev_stall   = 1'b0;
        for (int u = 0; u < 2; u++) begin
            ex_valid[u] = 1'b0;
            ex_op[u]    = RED_ADD;
            ex_tmask[u] = '0;
            ex_data[u]  = '0;
            ex_tag[u]   = '0;
            busy[u]     = 1'b0;
        end
        build_stimulus();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            drive_unit(0);
            drive_unit(1);
        join
        while (n_commits < TOTAL_COMMITS) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (exp_q0.size() == 0 && exp_q1.size() == 0 && !commit_valid) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("commits left over at the end of the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* include/red_params.svh */
`ifndef RED_PARAMS_SVH
`define RED_PARAMS_SVH

// width of one data word in bits
`define RED_XLEN 32

// lanes carried by one packet
`define RED_NUM_LANES 4

// threads in one warp
`define RED_NUM_THREADS 8

// a warp arrives as this many packets of RED_NUM_LANES lanes
`define RED_NUM_PACKETS (`RED_NUM_THREADS / `RED_NUM_LANES)

`endif

/* run.sh */
#!/bin/sh
# build and run the reduce cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_reduce_cluster -o tb_reduce_cluster
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_reduce_cluster > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

/* src.f */
+incdir+include
verilog/red_pkg.sv
verilog/red_ifs.sv
verilog/red_tree.sv
verilog/packet_fifo.sv
verilog/reduce_unit.sv
verilog/commit_arbiter.sv
verilog/reduce_cluster.sv
bench/tb_reduce_cluster.sv

/* verilog/commit_arbiter.sv */
`default_nettype none

module commit_arbiter (
    input  logic      clk,
    input  logic      reset,
    red_commit_if.dst req0,
    red_commit_if.dst req1,
    red_commit_if.src bus,
    output logic      grant_unit
);
    logic prio;
    logic lock;
    logic lock_unit;
    logic bus_fire;

    // a stalled grant stays put, else prio breaks a tie
    always_comb begin
        if (lock) begin
            grant_unit = lock_unit;
        end else if (req0.valid && req1.valid) begin
            grant_unit = prio;
        end else begin
            grant_unit = req1.valid;
        end
    end

    assign bus.valid = grant_unit ? req1.valid : req0.valid;
    assign bus.tmask = grant_unit ? req1.tmask : req0.tmask;
    assign bus.data  = grant_unit ? req1.data  : req0.data;
    assign bus.tag   = grant_unit ? req1.tag   : req0.tag;

    assign req0.ready = bus.ready && !grant_unit;
    assign req1.ready = bus.ready && grant_unit;

    assign bus_fire = bus.valid && bus.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio <= 1'b0;
            lock <= 1'b0;
        end else begin
            lock <= bus.valid && !bus.ready;
            // the loser of this transfer goes first next time
            if (bus_fire) begin
                prio <= !grant_unit;
            end
        end
    end

    always_ff @(posedge clk) begin
        lock_unit <= grant_unit;
    end

    assert property (@(posedge clk) disable iff (reset) !(req0.ready && req1.ready));

endmodule

`default_nettype wire

/* verilog/packet_fifo.sv */
`default_nettype none

module packet_fifo #(
    parameter int DEPTH = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               push,
    input  red_pkg::red_mask_t push_tmask,
    input  red_pkg::red_tag_t  push_tag,
    input  logic               pop,
    output red_pkg::red_mask_t head_tmask,
    output red_pkg::red_tag_t  head_tag,
    output logic               empty
);
    import red_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    red_mask_t       tmask_mem [DEPTH];
    red_tag_t        tag_mem   [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            full;

    assign empty      = (count == '0);
    assign full       = (count == CW'(DEPTH));
    assign head_tmask = tmask_mem[rd_ptr];
    assign head_tag   = tag_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            tmask_mem[wr_ptr] <= push_tmask;
            tag_mem[wr_ptr]   <= push_tag;
        end
    end

    // the unit must never store more packets than a warp has, nor pop a missing one
    assert property (@(posedge clk) disable iff (reset) !(push && full));
    assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

`default_nettype wire

/* verilog/red_ifs.sv */
`default_nettype none

`include "red_params.svh"

// one packet of a warp instruction heading into a reduce unit
interface red_exec_if;
    import red_pkg::*;

    logic                           valid;
    logic                           ready;
    red_op_e                        op;
    red_mask_t                      tmask;
    red_word_t [`RED_NUM_LANES-1:0] data;
    red_tag_t                       tag;

    modport src (output valid, op, tmask, data, tag, input ready);
    modport dst (input valid, op, tmask, data, tag, output ready);
endinterface

// one result packet leaving a reduce unit or the arbiter
interface red_commit_if;
    import red_pkg::*;

    logic                           valid;
    logic                           ready;
    red_mask_t                      tmask;
    red_word_t [`RED_NUM_LANES-1:0] data;
    red_tag_t                       tag;

    modport src (output valid, tmask, data, tag, input ready);
    modport dst (input valid, tmask, data, tag, output ready);
endinterface

`default_nettype wire

/* verilog/red_pkg.sv */
`default_nettype none

`include "red_params.svh"

package red_pkg;

    // reduction opcodes
    typedef enum logic [2:0] {
        RED_ADD,
        RED_MIN,
        RED_MINU,
        RED_MAX,
        RED_MAXU,
        RED_AND,
        RED_OR,
        RED_XOR
    } red_op_e;

    // reduce unit FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCUM,
        ST_BCAST
    } red_state_e;

    // pid needs at least one bit even for a single packet warp
    localparam int RED_PID_W = ($clog2(`RED_NUM_PACKETS) > 0) ? $clog2(`RED_NUM_PACKETS) : 1;

    typedef logic [`RED_XLEN-1:0]      red_word_t;
    typedef logic [`RED_NUM_LANES-1:0] red_mask_t;
    typedef logic [RED_PID_W-1:0]      red_pid_t;

    typedef struct packed {
        logic [1:0] wid;
        logic [4:0] rd;
        red_pid_t   pid;
        logic       sop;
        logic       eop;
    } red_tag_t;

endpackage

`default_nettype wire

/* verilog/red_tree.sv */
`default_nettype none

module red_tree #(
    parameter int N = 4
) (
    input  red_pkg::red_word_t [N-1:0] data,
    input  logic [N-1:0]               mask,
    input  red_pkg::red_op_e           op,
    output red_pkg::red_word_t         result,
    output logic                       any
);
    import red_pkg::*;

    if (N == 1) begin : g_leaf
        // an inactive lane reads as zero so an empty tree yields zero
        assign result = mask[0] ? data[0] : '0;
        assign any    = mask[0];
    end else begin : g_node
        localparam int NA = N / 2;
        localparam int NB = N - NA;

        red_word_t res_a;
        red_word_t res_b;
        red_word_t combined;
        logic      any_a;
        logic      any_b;

        red_tree #(
            .N (NA)
        ) u_lo (
            .data   (data[NA-1:0]),
            .mask   (mask[NA-1:0]),
            .op     (op),
            .result (res_a),
            .any    (any_a)
        );

        red_tree #(
            .N (NB)
        ) u_hi (
            .data   (data[N-1:NA]),
            .mask   (mask[N-1:NA]),
            .op     (op),
            .result (res_b),
            .any    (any_b)
        );

        always_comb begin
            case (op)
                RED_ADD:  combined = res_a + res_b;
                RED_MIN:  combined = ($signed(res_a) < $signed(res_b)) ? res_a : res_b;
                RED_MINU: combined = (res_a < res_b) ? res_a : res_b;
                RED_MAX:  combined = ($signed(res_a) < $signed(res_b)) ? res_b : res_a;
                RED_MAXU: combined = (res_a < res_b) ? res_b : res_a;
                RED_AND:  combined = res_a & res_b;
                RED_OR:   combined = res_a | res_b;
                RED_XOR:  combined = res_a ^ res_b;
                default:  combined = res_a;
            endcase
        end

        // skip a half with no active lane, otherwise it would pollute min, and and the like
        assign result = (any_a && any_b) ? combined : (any_a ? res_a : res_b);
        assign any    = any_a || any_b;
    end

endmodule

`default_nettype wire

/* verilog/reduce_cluster.sv */
`default_nettype none

`include "red_params.svh"

module reduce_cluster (
    input  logic                                     clk,
    input  logic                                     reset,

    input  logic                                     exec0_valid,
    input  red_pkg::red_op_e                         exec0_op,
    input  red_pkg::red_mask_t                       exec0_tmask,
    input  red_pkg::red_word_t [`RED_NUM_LANES-1:0]  exec0_data,
    input  red_pkg::red_tag_t                        exec0_tag,
    output logic                                     exec0_ready,

    input  logic                                     exec1_valid,
    input  red_pkg::red_op_e                         exec1_op,
    input  red_pkg::red_mask_t                       exec1_tmask,
    input  red_pkg::red_word_t [`RED_NUM_LANES-1:0]  exec1_data,
    input  red_pkg::red_tag_t                        exec1_tag,
    output logic                                     exec1_ready,

    output logic                                     commit_valid,
    input  logic                                     commit_ready,
    output red_pkg::red_mask_t                       commit_tmask,
    output red_pkg::red_word_t [`RED_NUM_LANES-1:0]  commit_data,
    output red_pkg::red_tag_t                        commit_tag,
    output logic                                     commit_unit
);
    red_exec_if   exec_if0 ();
    red_exec_if   exec_if1 ();
    red_commit_if unit_commit0 ();
    red_commit_if unit_commit1 ();
    red_commit_if bus_commit ();

    assign exec_if0.valid = exec0_valid;
    assign exec_if0.op    = exec0_op;
    assign exec_if0.tmask = exec0_tmask;
    assign exec_if0.data  = exec0_data;
    assign exec_if0.tag   = exec0_tag;
    assign exec0_ready    = exec_if0.ready;

    assign exec_if1.valid = exec1_valid;
    assign exec_if1.op    = exec1_op;
    assign exec_if1.tmask = exec1_tmask;
    assign exec_if1.data  = exec1_data;
    assign exec_if1.tag   = exec1_tag;
    assign exec1_ready    = exec_if1.ready;

    reduce_unit u_unit0 (
        .clk    (clk),
        .reset  (reset),
        .exec   (exec_if0),
        .commit (unit_commit0)
    );

    reduce_unit u_unit1 (
        .clk    (clk),
        .reset  (reset),
        .exec   (exec_if1),
        .commit (unit_commit1)
    );

    commit_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .req0       (unit_commit0),
        .req1       (unit_commit1),
        .bus        (bus_commit),
        .grant_unit (commit_unit)
    );

    assign commit_valid     = bus_commit.valid;
    assign commit_tmask     = bus_commit.tmask;
    assign commit_data      = bus_commit.data;
    assign commit_tag       = bus_commit.tag;
    assign bus_commit.ready = commit_ready;

endmodule

`default_nettype wire

/* verilog/reduce_unit.sv */
`default_nettype none

`include "red_params.svh"

module reduce_unit (
    input logic        clk,
    input logic        reset,
    red_exec_if.dst    exec,
    red_commit_if.src  commit
);
    import red_pkg::*;

    red_state_e state;
    red_state_e state_next;

    red_word_t  acc;
    logic       acc_valid;
    red_word_t  acc_next;
    logic       acc_any;

    red_word_t  pkt_result;
    logic       pkt_any;

    logic [1:0] wid_q;
    logic [4:0] rd_q;
    red_op_e    op_q;

    red_mask_t  head_tmask;
    red_tag_t   head_tag;
    logic       fifo_empty;

    logic       exec_fire;
    logic       commit_fire;

    // packets are taken every cycle until the warp is complete
    assign exec.ready  = (state != ST_BCAST);
    assign exec_fire   = exec.valid && exec.ready;
    assign commit_fire = commit.valid && commit.ready;

    // fold the active lanes of the incoming packet
    red_tree #(
        .N (`RED_NUM_LANES)
    ) u_lane_tree (
        .data   (exec.data),
        .mask   (exec.tmask),
        .op     (exec.op),
        .result (pkt_result),
        .any    (pkt_any)
    );

    // merge the packet result into the running value
    // a new instruction starts from a cleared accumulator, hence the sop term
    red_tree #(
        .N (2)
    ) u_acc_tree (
        .data   ({pkt_result, acc}),
        .mask   ({pkt_any, acc_valid && !exec.tag.sop}),
        .op     (exec.op),
        .result (acc_next),
        .any    (acc_any)
    );

    packet_fifo #(
        .DEPTH (`RED_NUM_PACKETS)
    ) u_pkt_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (exec_fire),
        .push_tmask (exec.tmask),
        .push_tag   (exec.tag),
        .pop        (commit_fire),
        .head_tmask (head_tmask),
        .head_tag   (head_tag),
        .empty      (fifo_empty)
    );

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE, ST_ACCUM: begin
                if (exec_fire) begin
                    state_next = exec.tag.eop ? ST_BCAST : ST_ACCUM;
                end
            end
            ST_BCAST: begin
                // the popped entry closes the warp
                if (commit_fire && head_tag.eop) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            acc_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (exec_fire) begin
                acc_valid <= acc_any;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exec_fire) begin
            acc   <= acc_next;
            wid_q <= exec.tag.wid;
            rd_q  <= exec.tag.rd;
            if (exec.tag.sop) begin
                op_q <= exec.op;
            end
        end
    end

    // each stored packet goes back with its own mask and flags and the shared result
    assign commit.valid = (state == ST_BCAST) && !fifo_empty;
    assign commit.tmask = head_tmask;
    assign commit.data  = {`RED_NUM_LANES{acc}};
    assign commit.tag   = '{wid: wid_q, rd: rd_q, pid: head_tag.pid,
                            sop: head_tag.sop, eop: head_tag.eop};

    // all packets of one instruction share the op given with sop
    assert property (@(posedge clk) disable iff (reset)
        exec_fire && !exec.tag.sop |-> exec.op == op_q);

endmodule

`default_nettype wire
